// File: verilog.f
+incdir+src
+incdir+test
src/ex_pkg.sv
src/ex_alu.sv
src/ex_shift.sv
src/ex_result.sv
src/ex_stage.sv
test/tb_ex_stage.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = tb_ex_stage
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run fails unless the pass message shows up in the simulation output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_ex_model.svh
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// Operand 1 is rs1 only when alu_src_pc is set, pc otherwise
function automatic data_t model_op1(input ex_ctrl_t c, input ex_data_t d);
    if (c.alu_src_pc) begin
        return d.rs1_data;
    end
    return d.pc;
endfunction

function automatic data_t model_op2(input ex_ctrl_t c, input ex_data_t d);
    if (c.alu_src_imm) begin
        return d.imm_data;
    end
    return d.rs2_data;
endfunction

function automatic data_t model_alu(input alu_op_e op, input data_t a, input data_t b);
    case (op)
        alu_add: return a + b;
        alu_sub: return a - b;
        alu_xor: return a ^ b;
        alu_or:  return a | b;
        alu_and: return a & b;
        default: return '0;
    endcase
endfunction

function automatic data_t model_shift(input shift_op_e op, input data_t a, input shamt_t amt);
    data_t ones;
    data_t fill;
    ones = '1;
    fill = ~(ones >> amt); // Bit positions vacated by a right shift
    case (op)
        shift_sll: return a << amt;
        shift_srl: return a >> amt;
        shift_sra: return (a >> amt) | ({`EX_DATA_W{a[`EX_DATA_W-1]}} & fill);
        default:   return '0;
    endcase
endfunction

// Branch conditions as RISC-V defines them
function automatic logic model_compare(input comp_type_e cmp, input data_t a, input data_t b);
    case (cmp)
        comp_eq:  return a == b;
        comp_ne:  return a != b;
        comp_lt:  return $signed(a) < $signed(b);
        comp_ltu: return a < b;
        comp_ge:  return $signed(a) >= $signed(b);
        comp_geu: return a >= b;
        default:  return 1'b0;
    endcase
endfunction

function automatic ex_out_t model_out(input ex_ctrl_t c, input ex_data_t d);
    ex_out_t r;
    data_t   a;
    data_t   b;
    logic    cmp;
    a   = model_op1(c, d);
    b   = model_op2(c, d);
    cmp = model_compare(c.comp_type, a, b);
    if (c.set_cond) begin
        r.rd_data = data_t'(cmp);
    end else if (c.shift_op != shift_none) begin
        r.rd_data = model_shift(c.shift_op, a, b[`EX_SHAMT_W-1:0]);
    end else begin
        r.rd_data = model_alu(c.alu_op, a, b);
    end
    r.branch_taken = ~c.set_cond & (c.comp_type != comp_none) & cmp;
    return r;
endfunction

`endif

// File: test/tb_ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module tb_ex_stage import ex_pkg::*; ();

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DLY      = 2;
    localparam int RESET_CYCLES   = 3;
    localparam int ALU_REPS       = 4;
    localparam int ALU_OPS        = 5 * 4 * ALU_REPS; // Five ops, four operand selections
    localparam int SHIFT_REPS     = 6;
    localparam int SHIFT_OPS      = 3 * SHIFT_REPS;
    localparam int PAIRS          = 9;
    localparam int BRANCH_OPS     = 6 * PAIRS;
    localparam int SET_OPS        = 2 * PAIRS;
    localparam int BURSTS         = 4;
    localparam int BURST_LEN      = 3;
    localparam int B2B_OPS        = BURSTS * BURST_LEN;
    localparam int TOTAL_OPS      = ALU_OPS + SHIFT_OPS + BRANCH_OPS + SET_OPS + B2B_OPS;
    localparam int TIMEOUT_CYCLES = TOTAL_OPS + 50;

    localparam data_t SIGN_BIT = data_t'(1) << (`EX_DATA_W - 1);

    logic     clk;
    logic     rst;
    logic     in_valid;
    ex_ctrl_t ctrl;
    ex_data_t data;
    logic     out_valid;
    ex_out_t  out;

    ex_out_t exp_q[$]; // One entry per operation in flight
    ex_out_t exp_out;
    logic    valid_d;
    logic    seen_valid = 1'b0;
    integer  seed;
    int      errors     = 0;
    int      checks     = 0;
    int      cycle_cnt  = 0;

    `include "tb_ex_model.svh"

    ex_stage i_ex_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .ctrl      (ctrl),
        .data      (data),
        .out_valid (out_valid),
        .out       (out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic data_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic ex_data_t rand_data();
        ex_data_t d;
        d.pc       = rand_word();
        d.rs1_data = rand_word();
        d.rs2_data = rand_word();
        d.imm_data = rand_word();
        return d;
    endfunction

    function automatic ex_ctrl_t make_ctrl(input logic src_pc, input logic src_imm,
                                           input alu_op_e aop, input shift_op_e sop,
                                           input comp_type_e cmp, input logic set_cond);
        ex_ctrl_t c;
        c.alu_src_pc  = src_pc;
        c.alu_src_imm = src_imm;
        c.alu_op      = aop;
        c.shift_op    = sop;
        c.comp_type   = cmp;
        c.set_cond    = set_cond;
        return c;
    endfunction

    function automatic alu_op_e pick_alu_op(input int k);
        case (k)
            0:       return alu_add;
            1:       return alu_sub;
            2:       return alu_xor;
            3:       return alu_or;
            default: return alu_and;
        endcase
    endfunction

    function automatic comp_type_e pick_comp(input int k);
        case (k)
            0:       return comp_eq;
            1:       return comp_ne;
            2:       return comp_lt;
            3:       return comp_ltu;
            4:       return comp_ge;
            default: return comp_geu;
        endcase
    endfunction

    // Pairs 1 to 4 sit on the sign boundary, where signed and unsigned order differ
    task automatic pick_pair(input int i, output data_t a, output data_t b);
        case (i)
            0: begin
                a = rand_word();
                b = a;
            end
            1: begin
                a = SIGN_BIT;
                b = data_t'(1);
            end
            2: begin
                a = data_t'(1);
                b = SIGN_BIT;
            end
            3: begin
                a = ~SIGN_BIT;
                b = SIGN_BIT;
            end
            4: begin
                a = '1;
                b = '0;
            end
            default: begin
                a = rand_word();
                b = rand_word();
            end
        endcase
    endtask

    task automatic check_value(input string name, input data_t exp, input data_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAIL at %0t ns: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic drive_op(input ex_ctrl_t c, input ex_data_t d);
        in_valid = 1'b1;
        ctrl     = c;
        data     = d;
        exp_q.push_back(model_out(c, d));
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic idle_cycle();
        in_valid = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic drive_compare(input comp_type_e cmp, input logic set_cond, input int i);
        ex_data_t d;
        data_t    a;
        data_t    b;
        pick_pair(i, a, b);
        d          = rand_data();
        d.rs1_data = a;
        if (i[0]) begin
            d.imm_data = b;
        end else begin
            d.rs2_data = b;
        end
        drive_op(make_ctrl(1'b1, i[0], alu_sub, shift_none, cmp, set_cond), d);
    endtask

    task automatic finish_test(input string name, input int ops, input int err_base);
        while (exp_q.size() != 0) begin
            idle_cycle();
        end
        idle_cycle();
        $display("test %s: %0d operations, %0d errors", name, ops, errors - err_base);
    endtask

    always @(posedge clk) begin
        valid_d <= in_valid & ~rst;
    end

    // Outputs are compared mid-cycle, well away from the registering edge
    always @(negedge clk) begin
        if (!rst) begin
            check_value("out_valid", data_t'(valid_d), data_t'(out_valid));
            if (!seen_valid && !valid_d) begin
                check_value("branch_taken", '0, data_t'(out.branch_taken));
            end
            if (valid_d) begin
                seen_valid = 1'b1;
                exp_out    = exp_q.pop_front();
                check_value("rd_data", exp_out.rd_data, out.rd_data);
                check_value("branch_taken", data_t'(exp_out.branch_taken),
                            data_t'(out.branch_taken));
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not complete", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        ex_ctrl_t c;
        ex_data_t d;
        int       err_base;

        seed     = 32'ha98e;
        rst      = 1'b1;
        in_valid = 1'b1; // Equal operands form a taken branch that reset has to hold off
        ctrl     = make_ctrl(1'b1, 1'b0, alu_sub, shift_none, comp_eq, 1'b0);
        data     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst      = 1'b0;
        in_valid = 1'b0;

        err_base = errors;
        repeat (2) idle_cycle();
        finish_test("reset", 0, err_base);

        err_base = errors;
        for (int k = 0; k < 5; k++) begin
            for (int sel = 0; sel < 4; sel++) begin
                for (int r = 0; r < ALU_REPS; r++) begin
                    c = make_ctrl(sel[1], sel[0], pick_alu_op(k), shift_none, comp_none, 1'b0);
                    drive_op(c, rand_data());
                end
            end
        end
        finish_test("alu", ALU_OPS, err_base);

        err_base = errors;
        for (int s = 1; s < 4; s++) begin
            for (int r = 0; r < SHIFT_REPS; r++) begin
                d = rand_data();
                if (r[0]) begin
                    d.rs1_data[`EX_DATA_W-1] = 1'b1; // Negative operand
                end
                if (r == 0) begin
                    d.rs2_data[`EX_SHAMT_W-1:0] = '0;
                end else if (r == 1) begin
                    d.rs2_data[`EX_SHAMT_W-1:0] = '1;
                end
                c = make_ctrl(1'b1, 1'b0, alu_none, shift_op_e'(s), comp_none, 1'b0);
                drive_op(c, d);
            end
        end
        finish_test("shift", SHIFT_OPS, err_base);

        err_base = errors;
        for (int t = 0; t < 6; t++) begin
            for (int i = 0; i < PAIRS; i++) begin
                drive_compare(pick_comp(t), 1'b0, i);
            end
        end
        finish_test("branch", BRANCH_OPS, err_base);

        err_base = errors;
        for (int i = 0; i < PAIRS; i++) begin
            drive_compare(comp_lt, 1'b1, i);
            drive_compare(comp_ltu, 1'b1, i);
        end
        finish_test("set_cond", SET_OPS, err_base);

        // Bursts on consecutive cycles, each followed by one idle cycle
        err_base = errors;
        for (int k = 0; k < BURSTS; k++) begin
            for (int j = 0; j < BURST_LEN; j++) begin
                c = make_ctrl(j[0], k[0], pick_alu_op((k + j) % 5), shift_none, comp_none, 1'b0);
                drive_op(c, rand_data());
            end
            idle_cycle();
        end
        finish_test("back_to_back", B2B_OPS, err_base);

        $display("tests: 6, operations: %0d, checks: %0d, errors: %0d",
                 TOTAL_OPS, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage import ex_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  ex_ctrl_t ctrl,
    input  ex_data_t data,
    output logic     out_valid,
    output ex_out_t  out
);

    ext_data_t alu_res;
    data_t     shift_res;

    // Arithmetic, logic and the compare difference
    ex_alu i_ex_alu (
        .ctrl    (ctrl),
        .data    (data),
        .alu_res (alu_res)
    );

    ex_shift i_ex_shift (
        .ctrl      (ctrl),
        .data      (data),
        .shift_res (shift_res)
    );

    // The only registers of the stage live here
    ex_result i_ex_result (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .ctrl      (ctrl),
        .alu_res   (alu_res),
        .shift_res (shift_res),
        .out_valid (out_valid),
        .out       (out)
    );

endmodule

`default_nettype wire

// File: src/ex_result.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module ex_result import ex_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  ex_ctrl_t  ctrl,
    input  ext_data_t alu_res,
    input  data_t     shift_res,
    output logic      out_valid,
    output ex_out_t   out
);

    logic  is_eq;
    logic  is_lt;
    logic  cmp_out;
    logic  branch_d;
    data_t rd_data_d;

    data_t rd_data_q;
    logic  branch_q;

    // Both flags come from the extended difference of a sub
    assign is_eq = alu_res[`EX_DATA_W-1:0] == '0;
    assign is_lt = alu_res[`EX_EXT_W-1];

    // Signedness is already folded into bit 64, so lt/ltu and ge/geu share logic
    always_comb begin
        case (ctrl.comp_type)
            comp_eq:  cmp_out = is_eq;
            comp_ne:  cmp_out = ~is_eq;
            comp_lt:  cmp_out = is_lt;
            comp_ltu: cmp_out = is_lt;
            comp_ge:  cmp_out = ~is_lt;
            comp_geu: cmp_out = ~is_lt;
            default:  cmp_out = 1'b0;
        endcase
    end

    always_comb begin
        if (ctrl.set_cond) begin
            rd_data_d = {{(`EX_DATA_W-1){1'b0}}, cmp_out};
        end else if (ctrl.shift_op != shift_none) begin
            rd_data_d = shift_res;
        end else begin
            rd_data_d = alu_res[`EX_DATA_W-1:0];
        end
    end

    // slt/sltu never branch, and an idle cycle never reports a taken branch
    assign branch_d = in_valid & ~ctrl.set_cond & (ctrl.comp_type != comp_none) & cmp_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            branch_q  <= 1'b0;
        end else begin
            out_valid <= in_valid;
            branch_q  <= branch_d;
        end
    end

    always_ff @(posedge clk) begin
        rd_data_q <= rd_data_d; // Only meaningful while out_valid is high
    end

    assign out.rd_data      = rd_data_q;
    assign out.branch_taken = branch_q;

endmodule

`default_nettype wire

// File: src/ex_shift.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module ex_shift import ex_pkg::*; (
    input  ex_ctrl_t ctrl,
    input  ex_data_t data,
    output data_t    shift_res
);

    data_t  op1;
    data_t  op2;
    shamt_t shamt;

    assign op1   = sel_op1(ctrl, data);
    assign op2   = sel_op2(ctrl, data);
    assign shamt = op2[`EX_SHAMT_W-1:0]; // Upper bits of the amount are ignored

    always_comb begin
        case (ctrl.shift_op)
            shift_sll: shift_res = op1 << shamt;
            shift_srl: shift_res = op1 >> shamt;
            shift_sra: shift_res = data_t'($signed(op1) >>> shamt); // Fill with the sign bit
            default:   shift_res = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/ex_alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module ex_alu import ex_pkg::*; (
    input  ex_ctrl_t  ctrl,
    input  ex_data_t  data,
    output ext_data_t alu_res
);

    logic is_add;
    logic is_sub;
    logic is_xor;
    logic is_or;
    logic is_and;
    logic comp_signed;

    data_t     op1_pre;
    data_t     op2_pre;
    ext_data_t op1;
    ext_data_t op2;
    ext_data_t arith_res;
    ext_data_t xor_res;
    ext_data_t or_res;
    ext_data_t and_res;

    assign is_add = ctrl.alu_op == alu_add;
    assign is_sub = ctrl.alu_op == alu_sub;
    assign is_xor = ctrl.alu_op == alu_xor;
    assign is_or  = ctrl.alu_op == alu_or;
    assign is_and = ctrl.alu_op == alu_and;

    assign comp_signed = ctrl.comp_type[2] & ctrl.comp_type[0];

    assign op1_pre = sel_op1(ctrl, data);
    assign op2_pre = sel_op2(ctrl, data);

    // Sign extension only for lt/ge, so that bit 64 of the difference
    // is the borrow for unsigned compares and the sign for signed ones
    assign op1 = {comp_signed & op1_pre[`EX_DATA_W-1], op1_pre};
    assign op2 = {comp_signed & op2_pre[`EX_DATA_W-1], op2_pre};

    assign arith_res = op1 + (is_sub ? (~op2 + ext_data_t'(1)) : op2); // Two's complement negate
    assign xor_res   = op1 ^ op2;
    assign or_res    = op1 | op2;
    assign and_res   = op1 & op2;

    // Decoded ops are one-hot, so masking and OR-ing replaces a mux
    assign alu_res = ({`EX_EXT_W{is_add | is_sub}} & arith_res)
                   | ({`EX_EXT_W{is_xor}}         & xor_res)
                   | ({`EX_EXT_W{is_or}}          & or_res)
                   | ({`EX_EXT_W{is_and}}         & and_res);

endmodule

`default_nettype wire

// File: src/ex_pkg.sv
`default_nettype none

`include "ex_params.svh"

package ex_pkg;

    typedef logic [`EX_DATA_W-1:0]  data_t;
    typedef logic [`EX_EXT_W-1:0]   ext_data_t;
    typedef logic [`EX_ADDR_W-1:0]  addr_t;
    typedef logic [`EX_SHAMT_W-1:0] shamt_t;

    typedef enum logic [2:0] {
        alu_none = 3'b000,
        alu_add  = 3'b011,
        alu_sub  = 3'b100,
        alu_xor  = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {
        shift_none = 2'b00,
        shift_sll  = 2'b01,
        shift_srl  = 2'b10,
        shift_sra  = 2'b11
    } shift_op_e;

    // Bit 2 marks an ordered compare, bit 0 with it marks a signed one
    typedef enum logic [2:0] {
        comp_none = 3'b000,
        comp_eq   = 3'b001,
        comp_ne   = 3'b010,
        comp_ltu  = 3'b100,
        comp_lt   = 3'b101,
        comp_geu  = 3'b110,
        comp_ge   = 3'b111
    } comp_type_e;

    typedef struct packed {
        logic       alu_src_pc;   // Clear picks pc as operand 1
        logic       alu_src_imm;
        alu_op_e    alu_op;
        shift_op_e  shift_op;
        comp_type_e comp_type;
        logic       set_cond;     // Write the compare outcome to rd for slt/sltu
    } ex_ctrl_t;

    typedef struct packed {
        addr_t pc;
        data_t rs1_data;
        data_t rs2_data;
        data_t imm_data;
    } ex_data_t;

    typedef struct packed {
        data_t rd_data;
        logic  branch_taken;
    } ex_out_t;

    // Both units see the same operands
    function automatic data_t sel_op1(input ex_ctrl_t ctrl, input ex_data_t data);
        return ctrl.alu_src_pc ? data.rs1_data : data.pc;
    endfunction

    function automatic data_t sel_op2(input ex_ctrl_t ctrl, input ex_data_t data);
        return ctrl.alu_src_imm ? data.imm_data : data.rs2_data;
    endfunction

endpackage

`default_nettype wire

// File: src/ex_params.svh
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Width of an integer register and of the operands of both units
`define EX_DATA_W 64

// One extra bit on top of the data word keeps the borrow or sign of a compare
`define EX_EXT_W 65

`define EX_ADDR_W 64 // Program counter width

// RV64 shifts use the low six bits of operand 2
`define EX_SHAMT_W 6

`endif
